//--- src/epu_params.svh
`ifndef EPU_PARAMS_SVH
`define EPU_PARAMS_SVH

// matrix geometry
`define EPU_ROWS    4
`define EPU_COLS    4
`define EPU_DATA_W  32

// word address into (rows + 1) * cols words, the last row holds the bias
`define EPU_ADDR_W  5

// ---------------------------------------
// instruction encoding
// ---------------------------------------
`define EPU_OPC_RTYPE  7'h33
`define EPU_F7_LAYER   7'h06
`define EPU_F7_BUF     7'h07

// funct3 under the layer funct7
`define EPU_F3_CFG     3'b000
`define EPU_F3_START   3'b001
`define EPU_F3_STAT    3'b010
`define EPU_F3_RCLASS  3'b011

// funct3 under the buffer funct7
`define EPU_F3_BWR     3'b000
`define EPU_F3_BRD     3'b001

`endif

//--- src/epu_pkg.sv
`include "epu_params.svh"

package epu_pkg;

  // standard r-type field layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rtype_t;

  typedef struct packed {
    logic [15:0] row;
    logic [15:0] col;
  } elem_addr_t;

  typedef struct packed {
    logic [14:0] rsvd;
    logic        relu_en;
    logic [15:0] argmax_row;
  } layer_cfg_t;

  // rs1 as seen by buffer ops or by layer cfg
  typedef union packed {
    elem_addr_t elem;
    layer_cfg_t cfg;
  } operand_u;

  typedef struct packed {
    logic                   we;
    logic [`EPU_ADDR_W-1:0] addr;
    logic [`EPU_DATA_W-1:0] wdata;
  } buf_req_t;

  typedef enum logic [2:0] {
    IDLE,
    EWISE,
    ARGMAX,
    DONE
  } phase_e;

  typedef struct packed {
    rtype_t      instr;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [4:0]  rd_addr;
  } cpu_instr_t;

  typedef struct packed {
    logic        we;
    logic [4:0]  waddr;
    logic [31:0] wdata;
  } cpu_wb_t;

endpackage

//--- src/matrix_buffer.sv
`timescale 1ns/1ps
`include "epu_params.svh"

module matrix_buffer (
  input  logic                   clk,
  input  logic                   req_i,
  input  epu_pkg::buf_req_t      breq_i,
  output logic [`EPU_DATA_W-1:0] rdata_o
);

  localparam int DEPTH = (`EPU_ROWS + 1) * `EPU_COLS;

  logic [`EPU_DATA_W-1:0] mem [DEPTH];

  // one port, read data lands one cycle after the request
  always_ff @(posedge clk) begin
    if (req_i) begin
      if (breq_i.we) begin
        mem[breq_i.addr] <= breq_i.wdata;
      end else begin
        rdata_o <= mem[breq_i.addr];
      end
    end
  end

endmodule

//--- src/buffer_arbiter.sv
`timescale 1ns/1ps
`include "epu_params.svh"

module buffer_arbiter
  import epu_pkg::*;
#(
  parameter int N_MASTERS = 3
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [N_MASTERS-1:0]   req_i,
  input  buf_req_t               breq_i [N_MASTERS],
  output logic [N_MASTERS-1:0]   gnt_o,
  output logic [N_MASTERS-1:0]   rvalid_o,
  output logic [`EPU_DATA_W-1:0] rdata_o
);

  localparam int SEL_W = $clog2(N_MASTERS);

  logic [SEL_W-1:0]     last_q;
  logic [SEL_W-1:0]     sel;
  logic                 found;
  int                   idx;
  logic                 mem_req;
  buf_req_t             mem_breq;
  logic [N_MASTERS-1:0] rd_tag_q;

  // ---------------------------------------
  // round robin, search starts after last winner
  // ---------------------------------------
  always_comb begin
    gnt_o = '0;
    sel   = last_q;
    found = 1'b0;
    idx   = 0;
    for (int i = 1; i <= N_MASTERS; i++) begin
      idx = (int'(last_q) + i) % N_MASTERS;
      if (!found && req_i[idx]) begin
        found      = 1'b1;
        gnt_o[idx] = 1'b1;
        sel        = SEL_W'(idx);
      end
    end
  end

  assign mem_req  = found;
  assign mem_breq = breq_i[sel];

  always_ff @(posedge clk) begin
    if (rst) begin
      last_q   <= SEL_W'(N_MASTERS - 1);
      rd_tag_q <= '0;
    end else begin
      if (found) begin
        last_q <= sel;
      end
      // remember who gets the read data next cycle
      rd_tag_q <= mem_breq.we ? '0 : gnt_o;
    end
  end

  assign rvalid_o = rd_tag_q;

  matrix_buffer u_mem (
    .clk     (clk),
    .req_i   (mem_req),
    .breq_i  (mem_breq),
    .rdata_o (rdata_o)
  );

  a_gnt_onehot : assert property (@(posedge clk) disable iff (rst) $onehot0(gnt_o));

endmodule

//--- src/host_port.sv
`timescale 1ns/1ps
`include "epu_params.svh"

module host_port
  import epu_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  cpu_instr_t                   cpu_instr_i,
  input  logic                         instr_valid_i,
  output logic                         instr_ready_o,
  output cpu_wb_t                      cpu_wb_o,
  input  logic                         busy_i,
  input  logic                         done_i,
  input  phase_e                       phase_i,
  input  logic [$clog2(`EPU_COLS)-1:0] class_idx_i,
  output logic                         cfg_we_o,
  output operand_u                     cfg_o,
  output logic                         start_o,
  output logic                         buf_req_o,
  output buf_req_t                     breq_o,
  input  logic                         buf_gnt_i,
  input  logic                         buf_rvalid_i,
  input  logic [`EPU_DATA_W-1:0]       buf_rdata_i
);

  rtype_t                 ins;
  operand_u               opnd;
  logic                   is_layer;
  logic                   is_buf;
  logic                   is_cfg;
  logic                   is_start;
  logic                   is_stat;
  logic                   is_rclass;
  logic                   is_bwr;
  logic                   is_brd;
  logic                   is_read;
  logic                   accept;
  logic                   pend;
  logic                   req_q;
  logic                   rd_wait_q;
  buf_req_t               breq_q;
  logic [4:0]             rd_q;
  logic                   wb_we_q;
  logic [4:0]             wb_addr_q;
  logic [`EPU_DATA_W-1:0] wb_data_q;
  logic [`EPU_DATA_W-1:0] stat_word;

  // ---------------------------------------
  // decode
  // ---------------------------------------
  assign ins  = cpu_instr_i.instr;
  assign opnd = cpu_instr_i.rs1_val;

  assign is_layer  = (ins.opcode == `EPU_OPC_RTYPE) && (ins.funct7 == `EPU_F7_LAYER);
  assign is_buf    = (ins.opcode == `EPU_OPC_RTYPE) && (ins.funct7 == `EPU_F7_BUF);
  assign is_cfg    = is_layer && (ins.funct3 == `EPU_F3_CFG);
  assign is_start  = is_layer && (ins.funct3 == `EPU_F3_START);
  assign is_stat   = is_layer && (ins.funct3 == `EPU_F3_STAT);
  assign is_rclass = is_layer && (ins.funct3 == `EPU_F3_RCLASS);
  assign is_bwr    = is_buf && (ins.funct3 == `EPU_F3_BWR);
  assign is_brd    = is_buf && (ins.funct3 == `EPU_F3_BRD);
  assign is_read   = is_stat || is_rclass;

  // one host buffer op at a time, reads stay pending until data is back
  assign pend = req_q || rd_wait_q;

  always_comb begin
    if (busy_i) begin
      instr_ready_o = is_read;
    end else if (is_bwr || is_brd) begin
      instr_ready_o = !pend;
    end else begin
      instr_ready_o = 1'b1;
    end
    // returning buffer data owns next cycle's writeback slot
    if (is_read && buf_rvalid_i) begin
      instr_ready_o = 1'b0;
    end
  end

  assign accept = instr_valid_i && instr_ready_o;

  assign cfg_we_o = accept && is_cfg;
  assign cfg_o    = opnd;
  assign start_o  = accept && is_start;

  // ---------------------------------------
  // buffer request
  // ---------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      req_q     <= 1'b0;
      rd_wait_q <= 1'b0;
    end else begin
      if (accept && (is_bwr || is_brd)) begin
        req_q <= 1'b1;
      end else if (buf_gnt_i) begin
        req_q <= 1'b0;
      end
      if (buf_gnt_i && !breq_q.we) begin
        rd_wait_q <= 1'b1;
      end else if (buf_rvalid_i) begin
        rd_wait_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && (is_bwr || is_brd)) begin
      breq_q <= '{we:    is_bwr,
                  addr:  `EPU_ADDR_W'(opnd.elem.row * `EPU_COLS + opnd.elem.col),
                  wdata: cpu_instr_i.rs2_val};
      rd_q   <= cpu_instr_i.rd_addr;
    end
  end

  assign buf_req_o = req_q;
  assign breq_o    = breq_q;

  // ---------------------------------------
  // writeback
  // ---------------------------------------
  assign stat_word = `EPU_DATA_W'({phase_i, done_i, busy_i});

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_we_q <= 1'b0;
    end else begin
      wb_we_q <= (accept && is_read) || (buf_rvalid_i && rd_wait_q);
    end
  end

  always_ff @(posedge clk) begin
    if (buf_rvalid_i) begin
      wb_addr_q <= rd_q;
      wb_data_q <= buf_rdata_i;
    end else if (accept) begin
      wb_addr_q <= cpu_instr_i.rd_addr;
      wb_data_q <= is_stat ? stat_word : `EPU_DATA_W'(class_idx_i);
    end
  end

  assign cpu_wb_o = '{we: wb_we_q, waddr: wb_addr_q, wdata: wb_data_q};

  // the engines own the buffer for the whole run
  a_no_host_req_busy : assert property (@(posedge clk) disable iff (rst)
    busy_i |-> !buf_req_o);

endmodule

//--- src/layer_sequencer.sv
`timescale 1ns/1ps
`include "epu_params.svh"

module layer_sequencer
  import epu_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         cfg_we_i,
  input  operand_u                     cfg_i,
  input  logic                         start_i,
  output logic                         ew_start_o,
  output logic                         relu_en_o,
  input  logic                         ew_done_i,
  output logic                         am_start_o,
  output logic [$clog2(`EPU_ROWS)-1:0] argmax_row_o,
  input  logic                         am_done_i,
  input  logic [$clog2(`EPU_COLS)-1:0] class_idx_i,
  output logic                         busy_o,
  output logic                         done_o,
  output phase_e                       phase_o,
  output logic [$clog2(`EPU_COLS)-1:0] class_idx_o
);

  localparam int ROW_W = $clog2(`EPU_ROWS);
  localparam int COL_W = $clog2(`EPU_COLS);

  phase_e           phase_q;
  logic             relu_q;
  logic [ROW_W-1:0] row_q;
  logic             done_q;
  logic             ew_start_q;
  logic             am_start_q;
  logic [COL_W-1:0] class_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      phase_q    <= IDLE;
      relu_q     <= 1'b0;
      row_q      <= '0;
      done_q     <= 1'b0;
      ew_start_q <= 1'b0;
      am_start_q <= 1'b0;
      class_q    <= '0;
    end else begin
      ew_start_q <= 1'b0;
      am_start_q <= 1'b0;

      if (cfg_we_i) begin
        relu_q <= cfg_i.cfg.relu_en;
        row_q  <= cfg_i.cfg.argmax_row[ROW_W-1:0];
      end

      case (phase_q)
        // DONE rests until the next start
        IDLE, DONE: begin
          if (start_i) begin
            phase_q    <= EWISE;
            ew_start_q <= 1'b1;
            done_q     <= 1'b0;
          end
        end
        EWISE: begin
          if (ew_done_i) begin
            phase_q    <= ARGMAX;
            am_start_q <= 1'b1;
          end
        end
        ARGMAX: begin
          if (am_done_i) begin
            phase_q <= DONE;
            class_q <= class_idx_i;
            done_q  <= 1'b1;
          end
        end
        default: phase_q <= IDLE;
      endcase
    end
  end

  assign busy_o       = (phase_q == EWISE) || (phase_q == ARGMAX);
  assign done_o       = done_q;
  assign phase_o      = phase_q;
  assign class_idx_o  = class_q;
  assign ew_start_o   = ew_start_q;
  assign am_start_o   = am_start_q;
  assign relu_en_o    = relu_q;
  assign argmax_row_o = row_q;

  a_done_in_phase : assert property (@(posedge clk) disable iff (rst)
    (ew_done_i |-> phase_q == EWISE) and (am_done_i |-> phase_q == ARGMAX));

endmodule

//--- src/ewise_engine.sv
`timescale 1ns/1ps
`include "epu_params.svh"

module ewise_engine
  import epu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_i,
  input  logic                   relu_en_i,
  output logic                   done_o,
  output logic                   buf_req_o,
  output buf_req_t               breq_o,
  input  logic                   buf_gnt_i,
  input  logic                   buf_rvalid_i,
  input  logic [`EPU_DATA_W-1:0] buf_rdata_i
);

  localparam int N_ELEM = `EPU_ROWS * `EPU_COLS;
  localparam int IDX_W  = $clog2(N_ELEM + 1);
  localparam logic [IDX_W-1:0] LAST = IDX_W'(N_ELEM);
  localparam logic [`EPU_ADDR_W-1:0] BIAS_BASE = `EPU_ADDR_W'(N_ELEM);

  logic                   run_q;
  logic [IDX_W-1:0]       rd_idx_q;
  logic [IDX_W-1:0]       wr_idx_q;
  logic [IDX_W-1:0]       ret_q;
  logic                   rd_bias_q;
  logic                   tag_bias_q;
  logic [`EPU_DATA_W-1:0] bias_q;
  logic [`EPU_DATA_W-1:0] sum_q;
  logic                   sum_vld_q;
  logic                   req_q;
  buf_req_t               breq_q;
  logic                   free;
  logic                   rd_ok;
  logic                   last_wr;
  logic [`EPU_ADDR_W-1:0] bias_addr;
  logic [`EPU_DATA_W-1:0] res;

  // a new request may be loaded once the held one is granted
  assign free = !req_q || buf_gnt_i;

  // bias may run ahead, the element waits until the previous one is written
  assign rd_ok = run_q && (rd_idx_q < LAST) && (rd_bias_q || rd_idx_q == wr_idx_q);

  assign last_wr   = buf_gnt_i && breq_q.we && (wr_idx_q == LAST);
  assign bias_addr = BIAS_BASE + `EPU_ADDR_W'(int'(rd_idx_q) % `EPU_COLS);

  // sum wraps at 32 bits
  always_comb begin
    res = buf_rdata_i + bias_q;
    if (relu_en_i && res[`EPU_DATA_W-1]) begin
      res = '0;
    end
  end

  // ---------------------------------------
  // control
  // ---------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      run_q     <= 1'b0;
      req_q     <= 1'b0;
      sum_vld_q <= 1'b0;
      done_o    <= 1'b0;
      rd_idx_q  <= '0;
      wr_idx_q  <= '0;
      ret_q     <= '0;
      rd_bias_q <= 1'b1;
    end else begin
      done_o <= last_wr;
      if (start_i && !run_q) begin
        run_q     <= 1'b1;
        rd_idx_q  <= '0;
        wr_idx_q  <= '0;
        ret_q     <= '0;
        rd_bias_q <= 1'b1;
      end else if (last_wr) begin
        run_q <= 1'b0;
      end

      if (buf_rvalid_i && !tag_bias_q) begin
        sum_vld_q <= 1'b1;
        ret_q     <= ret_q + 1'b1;
      end

      if (free) begin
        if (sum_vld_q) begin
          req_q     <= 1'b1;
          sum_vld_q <= 1'b0;
          wr_idx_q  <= wr_idx_q + 1'b1;
        end else if (rd_ok) begin
          req_q     <= 1'b1;
          rd_bias_q <= !rd_bias_q;
          if (!rd_bias_q) begin
            rd_idx_q <= rd_idx_q + 1'b1;
          end
        end else begin
          req_q <= 1'b0;
        end
      end
    end
  end

  // ---------------------------------------
  // data path
  // ---------------------------------------
  always_ff @(posedge clk) begin
    if (buf_gnt_i) begin
      tag_bias_q <= (breq_q.addr >= BIAS_BASE);
    end
    if (buf_rvalid_i) begin
      if (tag_bias_q) begin
        bias_q <= buf_rdata_i;
      end else begin
        sum_q <= res;
      end
    end
    if (free) begin
      if (sum_vld_q) begin
        breq_q <= '{we: 1'b1, addr: `EPU_ADDR_W'(wr_idx_q), wdata: sum_q};
      end else if (rd_ok) begin
        breq_q <= '{we:    1'b0,
                    addr:  rd_bias_q ? bias_addr : `EPU_ADDR_W'(rd_idx_q),
                    wdata: '0};
      end
    end
  end

  assign buf_req_o = req_q;
  assign breq_o    = breq_q;

  // element k may only be written after k+1 element reads returned
  a_write_after_read : assert property (@(posedge clk) disable iff (rst)
    (buf_req_o && breq_o.we) |-> (IDX_W'(breq_o.addr) < ret_q));

endmodule

//--- src/argmax_engine.sv
`timescale 1ns/1ps
`include "epu_params.svh"

module argmax_engine
  import epu_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start_i,
  input  logic [$clog2(`EPU_ROWS)-1:0] row_i,
  output logic                         done_o,
  output logic [$clog2(`EPU_COLS)-1:0] class_idx_o,
  output logic                         buf_req_o,
  output buf_req_t                     breq_o,
  input  logic                         buf_gnt_i,
  input  logic                         buf_rvalid_i,
  input  logic [`EPU_DATA_W-1:0]       buf_rdata_i
);

  localparam int COL_W = $clog2(`EPU_COLS);

  logic                          run_q;
  logic                          req_q;
  logic [COL_W-1:0]              col_q;
  logic signed [`EPU_DATA_W-1:0] best_q;
  logic [COL_W-1:0]              best_idx_q;
  logic                          take;
  logic                          last;

  // strictly greater, so ties keep the lower column
  assign take = (col_q == '0) || ($signed(buf_rdata_i) > best_q);
  assign last = (col_q == COL_W'(`EPU_COLS - 1));

  // one read outstanding, col_q stays put until its data is back
  always_ff @(posedge clk) begin
    if (rst) begin
      run_q  <= 1'b0;
      req_q  <= 1'b0;
      col_q  <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i && !run_q) begin
        run_q <= 1'b1;
        req_q <= 1'b1;
        col_q <= '0;
      end else if (buf_gnt_i) begin
        req_q <= 1'b0;
      end
      if (buf_rvalid_i) begin
        if (last) begin
          run_q  <= 1'b0;
          done_o <= 1'b1;
        end else begin
          col_q <= col_q + 1'b1;
          req_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (buf_rvalid_i && take) begin
      best_q     <= buf_rdata_i;
      best_idx_q <= col_q;
    end
  end

  assign buf_req_o   = req_q;
  assign breq_o      = '{we:    1'b0,
                         addr:  `EPU_ADDR_W'(int'(row_i) * `EPU_COLS + int'(col_q)),
                         wdata: '0};
  assign class_idx_o = best_idx_q;

endmodule

//--- src/epu_top.sv
`timescale 1ns/1ps
`include "epu_params.svh"

module epu_top
  import epu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  cpu_instr_t cpu_instr_i,
  input  logic       instr_valid_i,
  output logic       instr_ready_o,
  output cpu_wb_t    cpu_wb_o,
  output logic       accel_busy_o,
  output logic       accel_done_o
);

  localparam int ROW_W = $clog2(`EPU_ROWS);
  localparam int COL_W = $clog2(`EPU_COLS);

  // arbiter masters: 0 host, 1 ewise, 2 argmax
  logic [2:0]             req;
  logic [2:0]             gnt;
  logic [2:0]             rvalid;
  buf_req_t               breq [3];
  logic [`EPU_DATA_W-1:0] rdata;

  logic                   cfg_we;
  operand_u               cfg;
  logic                   start;
  phase_e                 phase;
  logic [COL_W-1:0]       seq_class;
  logic [COL_W-1:0]       am_class;
  logic                   ew_start;
  logic                   ew_done;
  logic                   relu_en;
  logic                   am_start;
  logic                   am_done;
  logic [ROW_W-1:0]       argmax_row;

  host_port u_host (
    .clk           (clk),
    .rst           (rst),
    .cpu_instr_i   (cpu_instr_i),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .cpu_wb_o      (cpu_wb_o),
    .busy_i        (accel_busy_o),
    .done_i        (accel_done_o),
    .phase_i       (phase),
    .class_idx_i   (seq_class),
    .cfg_we_o      (cfg_we),
    .cfg_o         (cfg),
    .start_o       (start),
    .buf_req_o     (req[0]),
    .breq_o        (breq[0]),
    .buf_gnt_i     (gnt[0]),
    .buf_rvalid_i  (rvalid[0]),
    .buf_rdata_i   (rdata)
  );

  layer_sequencer u_seq (
    .clk          (clk),
    .rst          (rst),
    .cfg_we_i     (cfg_we),
    .cfg_i        (cfg),
    .start_i      (start),
    .ew_start_o   (ew_start),
    .relu_en_o    (relu_en),
    .ew_done_i    (ew_done),
    .am_start_o   (am_start),
    .argmax_row_o (argmax_row),
    .am_done_i    (am_done),
    .class_idx_i  (am_class),
    .busy_o       (accel_busy_o),
    .done_o       (accel_done_o),
    .phase_o      (phase),
    .class_idx_o  (seq_class)
  );

  ewise_engine u_ewise (
    .clk          (clk),
    .rst          (rst),
    .start_i      (ew_start),
    .relu_en_i    (relu_en),
    .done_o       (ew_done),
    .buf_req_o    (req[1]),
    .breq_o       (breq[1]),
    .buf_gnt_i    (gnt[1]),
    .buf_rvalid_i (rvalid[1]),
    .buf_rdata_i  (rdata)
  );

  argmax_engine u_argmax (
    .clk          (clk),
    .rst          (rst),
    .start_i      (am_start),
    .row_i        (argmax_row),
    .done_o       (am_done),
    .class_idx_o  (am_class),
    .buf_req_o    (req[2]),
    .breq_o       (breq[2]),
    .buf_gnt_i    (gnt[2]),
    .buf_rvalid_i (rvalid[2]),
    .buf_rdata_i  (rdata)
  );

  buffer_arbiter u_arb (
    .clk      (clk),
    .rst      (rst),
    .req_i    (req),
    .breq_i   (breq),
    .gnt_o    (gnt),
    .rvalid_o (rvalid),
    .rdata_o  (rdata)
  );

endmodule

//--- tb/tb_epu.sv
`timescale 1ns/1ps
`include "epu_params.svh"

module tb_epu
  import epu_pkg::*;
();

  localparam logic [4:0]  RD_REG    = 5'd9;
  // phase DONE in bits 4:2, done set, busy clear
  localparam logic [31:0] STAT_DONE = 32'h0000000e;

  logic       clk = 1'b0;
  logic       rst;
  cpu_instr_t cpu_instr;
  logic       instr_valid;
  logic       instr_ready;
  cpu_wb_t    cpu_wb;
  logic       accel_busy;
  logic       accel_done;

  int               fd;
  int               code;
  int               line_count = 0;
  int               watch_cycles = 0;
  logic [8*160-1:0] line;
  int               test_num = 1;
  int               test_errs = 0;
  int               n_pass = 0;
  int               n_fail = 0;

  always #10 clk = ~clk;

  epu_top UUT (
    .clk           (clk),
    .rst           (rst),
    .cpu_instr_i   (cpu_instr),
    .instr_valid_i (instr_valid),
    .instr_ready_o (instr_ready),
    .cpu_wb_o      (cpu_wb),
    .accel_busy_o  (accel_busy),
    .accel_done_o  (accel_done)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
    test_errs++;
  endtask

  // drive from a falling edge, hold until the rising edge that accepts it
  task automatic send_instr(input logic [6:0] f7, input logic [2:0] f3,
                            input logic [31:0] rs1, input logic [31:0] rs2,
                            output logic busy_at_accept);
    rtype_t ins;
    ins = '{funct7: f7, rs2: 5'd2, rs1: 5'd1, funct3: f3, rd: RD_REG,
            opcode: `EPU_OPC_RTYPE};
    @(negedge clk);
    cpu_instr   = '{instr: ins, rs1_val: rs1, rs2_val: rs2, rd_addr: RD_REG};
    instr_valid = 1'b1;
    #1;
    while (!instr_ready) begin
      @(negedge clk);
      #1;
    end
    busy_at_accept = accel_busy;
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  task automatic wait_writeback(output logic [31:0] wdata);
    while (!cpu_wb.we) begin
      @(negedge clk);
    end
    if (cpu_wb.waddr !== RD_REG) begin
      report_mismatch("cpu_wb_o.waddr", 32'(RD_REG), 32'(cpu_wb.waddr));
    end
    wdata = cpu_wb.wdata;
  endtask

  task automatic read_stat(output logic [31:0] stat);
    logic busy_seen;
    send_instr(`EPU_F7_LAYER, `EPU_F3_STAT, 32'h0, 32'h0, busy_seen);
    wait_writeback(stat);
  endtask

  task automatic poll_until_done;
    logic [31:0] stat;
    read_stat(stat);
    while (!stat[1]) begin
      read_stat(stat);
    end
    if (stat !== STAT_DONE) begin
      report_mismatch("cpu_wb_o.wdata for STAT", STAT_DONE, stat);
    end
    if (accel_done !== 1'b1) begin
      report_mismatch("accel_done_o", 32'h1, {31'h0, accel_done});
    end
    if (accel_busy !== 1'b0) begin
      report_mismatch("accel_busy_o", 32'h0, {31'h0, accel_busy});
    end
  endtask

  task automatic close_test;
    if (test_errs == 0) begin
      $display("test %0d: ok", test_num);
      n_pass++;
    end else begin
      $display("test %0d: %0d errors", test_num, test_errs);
      n_fail++;
    end
    test_errs = 0;
    test_num++;
  endtask

  // ----------------------------------------
  // trace replay
  // ----------------------------------------
  task automatic run_trace;
    logic [7:0]  op;
    int          row;
    int          col;
    int          relu;
    logic [31:0] val;
    logic [31:0] data;
    logic        busy_seen;
    while ($fscanf(fd, "%s", op) == 1) begin
      case (op)
        "#": code = $fgets(line, fd);
        "W": begin
          code = $fscanf(fd, "%d %d %h", row, col, val);
          send_instr(`EPU_F7_BUF, `EPU_F3_BWR, {row[15:0], col[15:0]}, val, busy_seen);
        end
        "R": begin
          code = $fscanf(fd, "%d %d %h", row, col, val);
          send_instr(`EPU_F7_BUF, `EPU_F3_BRD, {row[15:0], col[15:0]}, 32'h0, busy_seen);
          wait_writeback(data);
          if (data !== val) begin
            report_mismatch($sformatf("cpu_wb_o.wdata for element %0d,%0d", row, col),
                            val, data);
          end
        end
        "C": begin
          code = $fscanf(fd, "%d %d", relu, row);
          send_instr(`EPU_F7_LAYER, `EPU_F3_CFG, {15'h0, relu[0], row[15:0]}, 32'h0,
                     busy_seen);
        end
        "S": begin
          send_instr(`EPU_F7_LAYER, `EPU_F3_START, 32'h0, 32'h0, busy_seen);
          read_stat(data);
          if (data[0] !== 1'b1) begin
            report_mismatch("cpu_wb_o.wdata[0] for STAT", 32'h1, {31'h0, data[0]});
          end
          // start clears the done flag of the previous run
          if (accel_done !== 1'b0) begin
            report_mismatch("accel_done_o", 32'h0, {31'h0, accel_done});
          end
          poll_until_done();
        end
        "K": begin
          code = $fscanf(fd, "%h", val);
          send_instr(`EPU_F7_LAYER, `EPU_F3_RCLASS, 32'h0, 32'h0, busy_seen);
          wait_writeback(data);
          if (data !== val) begin
            report_mismatch("cpu_wb_o.wdata for RCLASS", val, data);
          end
        end
        "B": begin
          code = $fscanf(fd, "%d %d %h", row, col, val);
          send_instr(`EPU_F7_LAYER, `EPU_F3_START, 32'h0, 32'h0, busy_seen);
          send_instr(`EPU_F7_BUF, `EPU_F3_BWR, {row[15:0], col[15:0]}, val, busy_seen);
          if (busy_seen) begin
            $display("buffer write at %0t was accepted while the layer run was busy", $time);
            test_errs++;
          end
          poll_until_done();
        end
        "T": close_test();
        default: begin
          $display("unknown op %s in the trace at %0t", op, $time);
          test_errs++;
          code = $fgets(line, fd);
        end
      endcase
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    rst         = 1'b1;
    instr_valid = 1'b0;
    cpu_instr   = '0;
    fd = $fopen("tb/epu_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file tb/epu_trace.txt");
      $display("test failed");
      $finish;
    end else begin
      // size the watchdog from the trace length
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code != 0) begin
          line_count++;
        end
      end
      $fclose(fd);
      watch_cycles = 200 * line_count + 20;
      fd = $fopen("tb/epu_trace.txt", "r");
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      run_trace();
      $fclose(fd);
      if (test_errs != 0) begin
        $display("errors after the last test: %0d", test_errs);
        n_fail++;
      end
      $display("tests: %0d passed, %0d failed", n_pass, n_fail);
      if (n_fail == 0 && n_pass > 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

  // watchdog
  initial begin
    wait (watch_cycles != 0);
    repeat (watch_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the DUT stopped answering", watch_cycles);
    $display("test failed");
    $finish;
  end

endmodule

//--- all.f
+incdir+src
src/epu_pkg.sv
src/matrix_buffer.sv
src/buffer_arbiter.sv
src/host_port.sv
src/layer_sequencer.sv
src/ewise_engine.sv
src/argmax_engine.sv
src/epu_top.sv
tb/tb_epu.sv

//--- Makefile
# Verilator build of the EPU testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tb_epu -o tb_epu

# prints the simulation output and fails unless the pass line shows up
run: compile
	./obj_dir/tb_epu | awk '{ print } /^test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- tb/epu_trace.txt
# ops: W row col value, R row col expected, C relu_en row, S, K expected, B row col value, T
# rows and cols decimal, data hex, row 4 is the bias row, B starts a run then writes, T ends a test
W 1 0 00000005
W 1 1 fffffff0
W 1 2 00000007
W 1 3 80000000
W 4 0 00000001
W 4 1 00000020
W 4 2 fffffffe
W 4 3 ffffffff
R 1 1 fffffff0
R 4 2 fffffffe
T
C 0 1
S
R 1 0 00000006
R 1 1 00000010
R 1 2 00000005
R 1 3 7fffffff
K 3
T
W 2 0 00000002
W 2 1 ffffffea
W 2 2 fffffff0
W 2 3 0000000b
C 1 2
S
R 2 1 0000000a
R 2 2 00000000
R 2 3 0000000a
K 1
T
B 3 0 12345678
R 3 0 12345678
T
